// ==== files.f ====
+incdir+src
+incdir+tests
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/qnt_fsm.sv
src/qnt_node_counter.sv
src/qnt_unit.sv
src/ex_writeback.sv
src/ex_stage.sv
tests/ex_stage_tb.sv

// ==== src/ex_alu.sv ====
// Integer ALU of the execute stage, purely combinational
// cmp_result_o doubles as the branch decision
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_alu import ex_pkg::*; (
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    cmp_result_o
);

  localparam int SHAMT_W = $clog2(`EX_WORD_W);

  logic [SHAMT_W-1:0] shamt;
  logic               eq;
  logic               lt_s;
  logic               lt_u;

  assign shamt = operand_b_i[SHAMT_W-1:0];  // Only the low bits count
  assign eq    = (operand_a_i == operand_b_i);
  assign lt_s  = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_u  = (operand_a_i < operand_b_i);

  // Comparison bit
  always_comb begin
    case (operator_i)
      ALU_EQ:          cmp_result_o = eq;
      ALU_NE:          cmp_result_o = ~eq;
      ALU_SLT, ALU_LT: cmp_result_o = lt_s;
      ALU_GE:          cmp_result_o = ~lt_s;
      ALU_SLTU,
      ALU_LTU:         cmp_result_o = lt_u;
      ALU_GEU:         cmp_result_o = ~lt_u;
      default:         cmp_result_o = 1'b0;
    endcase
  end

  // Result mux
  always_comb begin
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      ALU_SRA: result_o = word_t'($signed(operand_a_i) >>> shamt);
      default: result_o = word_t'(cmp_result_o);  // All compares, zero-extended
    endcase
  end

endmodule

// ==== src/ex_mult.sv ====
// Single-cycle multiplier: MUL, MAC, MULH and MULHU
// One shared product, sign handling picked by the operation
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_mult import ex_pkg::*; (
  input  mult_op_e operator_i,
  input  word_t    op_a_i,
  input  word_t    op_b_i,
  input  word_t    op_c_i,
  output word_t    result_o
);

  localparam int W = `EX_WORD_W;

  logic                  is_signed;
  logic signed [W:0]     a_ext;
  logic signed [W:0]     b_ext;
  logic signed [2*W+1:0] prod_full;
  logic [2*W-1:0]        prod;

  // Low word is the same either way, so only MULH needs signed operands
  assign is_signed = (operator_i == MUL_MULH);

  assign a_ext = {is_signed & op_a_i[W-1], op_a_i};
  assign b_ext = {is_signed & op_b_i[W-1], op_b_i};

  assign prod_full = a_ext * b_ext;
  assign prod      = prod_full[2*W-1:0];

  always_comb begin
    case (operator_i)
      MUL_MAC:   result_o = prod[W-1:0] + op_c_i;  // Accumulate on the low word
      MUL_MULH,
      MUL_MULHU: result_o = prod[2*W-1:W];
      default:   result_o = prod[W-1:0];
    endcase
  end

endmodule

// ==== src/ex_params.svh ====
// Widths and quantizer constants shared by the execute stage RTL
// Include wherever one of the macros below is referenced
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Datapath
`define EX_WORD_W        32
`define EX_REG_ADDR_W    6

// Threshold tree walk
`define QNT_LEVELS       4   // Tree depth, also number of result bits
`define QNT_ADDR_STRIDE  4   // Bytes between thresholds in memory

`endif

// ==== src/ex_pkg.sv ====
// Types shared by the execute stage modules
// Import with a wildcard in the module header
`include "ex_params.svh"

package ex_pkg;

  typedef logic [`EX_WORD_W-1:0]             word_t;
  typedef logic [`EX_REG_ADDR_W-1:0]         reg_addr_t;
  typedef logic [`QNT_LEVELS:0]              qnt_node_t;   // Heap-style node index
  typedef logic [$clog2(`QNT_LEVELS+1)-1:0]  qnt_level_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,   // Branch compares from here on
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL_MUL,
    MUL_MAC,
    MUL_MULH,
    MUL_MULHU
  } mult_op_e;

  typedef enum logic [1:0] {
    QNT_IDLE,
    QNT_REQ,
    QNT_WAIT,
    QNT_DONE
  } qnt_state_e;

endpackage

// ==== src/ex_stage.sv ====
// Execute stage: ALU, multiplier, quantization unit and write ports
// Sits between the ID stage and the WB stage, stalls via ex_ready_o
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // ALU
  input  logic      alu_en_i,
  input  alu_op_e   alu_operator_i,
  input  word_t     alu_operand_a_i,
  input  word_t     alu_operand_b_i,
  input  word_t     alu_operand_c_i,    // Jump target

  // Multiplier
  input  logic      mult_en_i,
  input  mult_op_e  mult_operator_i,
  input  word_t     mult_operand_a_i,
  input  word_t     mult_operand_b_i,
  input  word_t     mult_operand_c_i,

  // Quantization and threshold fetch
  input  logic      qnt_en_i,
  input  word_t     qnt_op_a_i,
  input  word_t     qnt_op_b_i,
  output logic      qnt_thresh_req_o,
  output word_t     qnt_thresh_addr_o,
  input  logic      data_gnt_mem_i,
  input  logic      data_rvalid_ex_i,

  // LSU
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,

  // CSR
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,

  // Branches
  input  logic      branch_in_ex_i,
  output word_t     jump_target_o,
  output logic      branch_decision_o,

  // Register file controls from ID
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,

  // Forward port
  output logic      regfile_alu_we_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output word_t     regfile_alu_wdata_fw_o,

  // LSU write port
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o,

  // Stall control
  output logic      ex_ready_o,
  output logic      ex_valid_o,
  input  logic      wb_ready_i
);

  word_t alu_result;
  word_t mult_result;
  word_t qnt_result;
  logic  qnt_ready;
  logic  units_ready;
  logic  ex_valid;

  //////////////////////////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////////////////////////

  ex_alu u_ex_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  assign jump_target_o = alu_operand_c_i;

  ex_mult u_ex_mult (
    .operator_i (mult_operator_i),
    .op_a_i     (mult_operand_a_i),
    .op_b_i     (mult_operand_b_i),
    .op_c_i     (mult_operand_c_i),
    .result_o   (mult_result)
  );

  qnt_unit u_qnt_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable_i      (qnt_en_i),
    .gnt_i         (data_gnt_mem_i),
    .rvalid_i      (data_rvalid_ex_i),
    .ex_ready_i    (ex_ready_o),
    .op_a_i        (qnt_op_a_i),
    .op_b_i        (qnt_op_b_i),
    .threshold_i   (lsu_rdata_i),      // Thresholds come back on the load data bus
    .thresh_req_o  (qnt_thresh_req_o),
    .thresh_addr_o (qnt_thresh_addr_o),
    .result_o      (qnt_result),
    .ready_o       (qnt_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Write ports
  //////////////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  ex_writeback u_ex_writeback (
    .clk             (clk),
    .rst_n           (rst_n),
    .alu_en_i        (alu_en_i),
    .mult_en_i       (mult_en_i),
    .qnt_en_i        (qnt_en_i),
    .csr_access_i    (csr_access_i),
    .ex_valid_i      (ex_valid),
    .wb_ready_i      (wb_ready_i),
    .regfile_we_i    (regfile_we_i),
    .lsu_err_i       (lsu_err_i),
    .alu_result_i    (alu_result),
    .mult_result_i   (mult_result),
    .qnt_result_i    (qnt_result),
    .csr_rdata_i     (csr_rdata_i),
    .lsu_rdata_i     (lsu_rdata_i),
    .regfile_waddr_i (regfile_waddr_i),
    .fw_wdata_o      (regfile_alu_wdata_fw_o),
    .wb_wdata_o      (regfile_wdata_wb_o),
    .wb_we_o         (regfile_we_wb_o),
    .wb_waddr_o      (regfile_waddr_wb_o)
  );

  // Stall logic
  // A branch resolves here and never needs WB, so it cannot be held up
  assign units_ready = qnt_ready & lsu_ready_ex_i & wb_ready_i;

  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid   = (alu_en_i | mult_en_i | qnt_en_i | csr_access_i | lsu_en_i)
                      & units_ready;
  assign ex_valid_o = ex_valid;

endmodule

// ==== src/ex_writeback.sv ====
// Write ports of the execute stage
// Forward port data mux and the EX/WB register of the LSU port
`timescale 1ns/1ps

module ex_writeback import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      qnt_en_i,
  input  logic      csr_access_i,
  input  logic      ex_valid_i,
  input  logic      wb_ready_i,
  input  logic      regfile_we_i,
  input  logic      lsu_err_i,
  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  word_t     qnt_result_i,
  input  word_t     csr_rdata_i,
  input  word_t     lsu_rdata_i,
  input  reg_addr_t regfile_waddr_i,
  output word_t     fw_wdata_o,
  output word_t     wb_wdata_o,
  output logic      wb_we_o,
  output reg_addr_t wb_waddr_o
);

  logic      lsu_we;
  logic      we_q;
  reg_addr_t waddr_q;

  //////////////////////////////////////////////////////////////////////
  // Forward port
  //////////////////////////////////////////////////////////////////////

  // Later sources override earlier ones
  always_comb begin
    fw_wdata_o = '0;
    if (alu_en_i)     fw_wdata_o = alu_result_i;
    if (mult_en_i)    fw_wdata_o = mult_result_i;
    if (qnt_en_i)     fw_wdata_o = qnt_result_i;
    if (csr_access_i) fw_wdata_o = csr_rdata_i;
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  assign lsu_we = regfile_we_i & ~lsu_err_i;  // Faulting loads never write

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_i) begin
      we_q <= lsu_we;
    end else if (wb_ready_i) begin
      we_q <= 1'b0;  // Bubble moves into WB
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i && lsu_we) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  assign wb_we_o    = we_q;
  assign wb_waddr_o = waddr_q;
  assign wb_wdata_o = lsu_rdata_i;  // Load data arrives in the WB cycle

endmodule

// ==== src/qnt_fsm.sv ====
// Sequencer of the threshold walk: one request and one response per level
// Holds the result in DONE until the stage moves on
`timescale 1ns/1ps

module qnt_fsm import ex_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic enable_i,
  input  logic gnt_i,
  input  logic rvalid_i,
  input  logic last_level_i,
  input  logic ex_ready_i,
  output logic req_o,
  output logic sample_o,
  output logic ready_o
);

  qnt_state_e state_q;
  qnt_state_e state_d;

  always_comb begin
    state_d  = state_q;
    sample_o = 1'b0;

    case (state_q)
      QNT_IDLE: begin
        if (enable_i) state_d = QNT_REQ;
      end
      QNT_REQ: begin
        if (gnt_i) state_d = QNT_WAIT;  // Request done, address may change
      end
      QNT_WAIT: begin
        if (rvalid_i) begin
          sample_o = 1'b1;
          state_d  = last_level_i ? QNT_DONE : QNT_REQ;
        end
      end
      QNT_DONE: begin
        if (ex_ready_i) state_d = QNT_IDLE;
      end
      default: state_d = QNT_IDLE;
    endcase
  end

  assign req_o = (state_q == QNT_REQ);

  // Not busy unless a walk is in progress
  assign ready_o = ~enable_i | (state_q == QNT_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= QNT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== src/qnt_node_counter.sv ====
// Node index and level count of the threshold tree walk
// Each step appends the compare bit below the current node
`timescale 1ns/1ps
`include "ex_params.svh"

module qnt_node_counter import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start_i,
  input  logic      step_i,
  input  logic      bit_i,
  output qnt_node_t node_o,
  output logic      last_level_o
);

  qnt_node_t  node_q;
  qnt_level_t level_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_q  <= qnt_node_t'(1);   // Root
      level_q <= '0;
    end else if (start_i) begin
      node_q  <= qnt_node_t'(1);
      level_q <= '0;
    end else if (step_i) begin
      node_q  <= {node_q[`QNT_LEVELS-1:0], bit_i};  // 2*node + bit
      level_q <= level_q + qnt_level_t'(1);
    end
  end

  assign node_o       = node_q;
  assign last_level_o = (level_q == qnt_level_t'(`QNT_LEVELS - 1));

endmodule

// ==== src/qnt_unit.sv ====
// Quantization unit: binary search of a threshold tree in data memory
// Result is the leaf index reached after QNT_LEVELS compares
`timescale 1ns/1ps
`include "ex_params.svh"

module qnt_unit import ex_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  enable_i,
  input  logic  gnt_i,
  input  logic  rvalid_i,
  input  logic  ex_ready_i,
  input  word_t op_a_i,
  input  word_t op_b_i,        // Base address of the threshold table
  input  word_t threshold_i,
  output logic  thresh_req_o,
  output word_t thresh_addr_o,
  output word_t result_o,
  output logic  ready_o
);

  qnt_node_t node;
  logic      sample;
  logic      last_level;
  logic      go_right;
  logic      restart;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  qnt_fsm u_qnt_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .gnt_i        (gnt_i),
    .rvalid_i     (rvalid_i),
    .last_level_i (last_level),
    .ex_ready_i   (ex_ready_i),
    .req_o        (thresh_req_o),
    .sample_o     (sample),
    .ready_o      (ready_o)
  );

  // Back to the root whenever the stage accepts the unit as finished
  assign restart = ready_o & ex_ready_i;

  qnt_node_counter u_qnt_node_counter (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (restart),
    .step_i       (sample),
    .bit_i        (go_right),
    .node_o       (node),
    .last_level_o (last_level)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  assign thresh_addr_o = op_b_i + word_t'(node) * word_t'(`QNT_ADDR_STRIDE);

  assign go_right = ($signed(op_a_i) >= $signed(threshold_i));  // Signed compare

  // Drop the leading one of the final node
  assign result_o = word_t'(node[`QNT_LEVELS-1:0]);

endmodule

// ==== tests/ex_stage_tests.svh ====
// Directed tests of the execute stage, one task per behavior
// Included inside the testbench module and works on its signals and helpers

//////////////////////////////////////////////////////////////////////
// Reference models
//////////////////////////////////////////////////////////////////////

function automatic logic cmp_model(input alu_op_e op, input word_t a, input word_t b);
  logic lt_u;
  logic lt_s;
  lt_u = (a < b);
  lt_s = (a[W-1] != b[W-1]) ? a[W-1] : lt_u;  // Differing signs decide alone
  case (op)
    ALU_SLT, ALU_LT:   return lt_s;
    ALU_SLTU, ALU_LTU: return lt_u;
    ALU_GE:            return !lt_s;
    ALU_GEU:           return !lt_u;
    ALU_EQ:            return a == b;
    ALU_NE:            return a != b;
    default:           return 1'b0;
  endcase
endfunction

function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
  int    sh;
  word_t fill;
  sh   = b[4:0];
  fill = a[W-1] ? ~(32'hFFFF_FFFF >> sh) : '0;  // Sign bits shifted in
  case (op)
    ALU_ADD: return a + b;
    ALU_SUB: return a + ~b + 1;
    ALU_AND: return a & b;
    ALU_OR:  return a | b;
    ALU_XOR: return a ^ b;
    ALU_SLL: return a << sh;
    ALU_SRL: return a >> sh;
    ALU_SRA: return (a >> sh) | fill;
    default: return word_t'(cmp_model(op, a, b));
  endcase
endfunction

function automatic word_t mult_model(input mult_op_e op, input word_t a, input word_t b,
                                     input word_t c);
  logic [2*W-1:0] pu;
  logic [2*W-1:0] ps;
  pu = {{W{1'b0}}, a} * {{W{1'b0}}, b};
  ps = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};  // Low 64 bits give the signed product
  case (op)
    MUL_MUL:  return pu[W-1:0];
    MUL_MAC:  return pu[W-1:0] + c;
    MUL_MULH: return ps[2*W-1:W];
    default:  return pu[2*W-1:W];
  endcase
endfunction

// Replays the tree rule on the table, checks fetch order and forward data
task automatic check_walk(input word_t op_a, input word_t base);
  int    node;
  int    lvl;
  word_t addr;
  require_true(fetched.size() == `QNT_LEVELS, "threshold fetch count differs from tree depth");
  node = 1;
  for (lvl = 0; lvl < `QNT_LEVELS; lvl++) begin
    addr = base + word_t'(node * `QNT_ADDR_STRIDE);
    if (lvl < fetched.size()) begin
      compare_value("qnt_thresh_addr_o", fetched[lvl], addr);
    end
    node = ($signed(op_a) >= $signed(thresh_at(addr))) ? 2 * node + 1 : 2 * node;
  end
  compare_value("qnt_thresh_req_o", qnt_thresh_req_o, 1'b0);  // No fetch once done
  compare_value("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o,
                word_t'(node - (1 << `QNT_LEVELS)));
endtask

//////////////////////////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////////////////////////

task automatic alu_test();
  word_t a;
  word_t b;
  int    i;
  for (i = 0; i < 16; i++) begin
    a = $random(seed);
    b = $random(seed);
    step_cycle();
    alu_en_i            = 1'b1;
    alu_operator_i      = alu_op_e'(i);
    alu_operand_a_i     = a;
    alu_operand_b_i     = b;
    regfile_alu_we_i    = i[0];  // Both enable levels get seen
    regfile_alu_waddr_i = reg_addr_t'(i + 3);
    @(negedge clk);
    compare_value("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o,
                  alu_model(alu_op_e'(i), a, b));
    compare_value("regfile_alu_we_fw_o", regfile_alu_we_fw_o, i[0]);
    compare_value("regfile_alu_waddr_fw_o", regfile_alu_waddr_fw_o, reg_addr_t'(i + 3));
    compare_value("ex_valid_o", ex_valid_o, 1'b1);
  end
  report_test("alu");
endtask

task automatic branch_test();
  word_t a;
  word_t b;
  word_t target;
  int    p;
  int    k;
  for (p = 0; p < 3; p++) begin
    a = $random(seed);
    case (p)
      0:       b = a;    // Equal operands
      1:       b = ~a;   // Opposite signs
      default: b = $random(seed);
    endcase
    for (k = int'(ALU_EQ); k <= int'(ALU_GEU); k++) begin
      target = $random(seed);
      step_cycle();
      branch_in_ex_i  = 1'b1;
      wb_ready_i      = 1'b0;
      alu_en_i        = 1'b1;
      alu_operator_i  = alu_op_e'(k);
      alu_operand_a_i = a;
      alu_operand_b_i = b;
      alu_operand_c_i = target;
      @(negedge clk);
      compare_value("branch_decision_o", branch_decision_o,
                    cmp_model(alu_op_e'(k), a, b));
      compare_value("jump_target_o", jump_target_o, target);
      compare_value("ex_ready_o", ex_ready_o, 1'b1);
    end
  end
  step_cycle();
  branch_in_ex_i = 1'b0;  // Now the WB stall holds the stage
  @(negedge clk);
  compare_value("ex_ready_o", ex_ready_o, 1'b0);
  report_test("branch");
endtask

task automatic mult_test();
  word_t a;
  word_t b;
  word_t c;
  int    n;
  int    k;
  for (n = 0; n < 4; n++) begin
    a = (n == 0) ? 32'h8000_0000 : $random(seed);
    b = (n == 0) ? 32'hFFFF_FFFF : $random(seed);
    c = $random(seed);
    for (k = 0; k < 4; k++) begin
      step_cycle();
      alu_en_i         = 1'b1;  // Multiplier must win over the ALU
      mult_en_i        = 1'b1;
      mult_operator_i  = mult_op_e'(k);
      mult_operand_a_i = a;
      mult_operand_b_i = b;
      mult_operand_c_i = c;
      @(negedge clk);
      compare_value("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o,
                    mult_model(mult_op_e'(k), a, b, c));
    end
  end
  step_cycle();
  csr_access_i = 1'b1;
  csr_rdata_i  = $random(seed);
  @(negedge clk);
  compare_value("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, csr_rdata_i);
  report_test("mult");
endtask

task automatic quantize_test();
  word_t op_a;
  word_t base;
  int    n;
  int    cycles;
  for (n = 0; n < 5; n++) begin
    case (n)
      0:       op_a = 32'h7FFF_FFFF;  // Right at every level
      1:       op_a = 32'h8000_0000;  // Left at every level
      default: op_a = $random(seed) % 160;
    endcase
    base = word_t'((n % 3) * 64);
    fetched.delete();
    step_cycle();
    qnt_en_i         = 1'b1;
    qnt_op_a_i       = op_a;
    qnt_op_b_i       = base;
    regfile_alu_we_i = 1'b1;
    cycles           = 0;
    @(negedge clk);
    while (!ex_valid_o && cycles < WORST_QNT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    require_true(ex_valid_o, "quantization never raised ex_valid_o");
    check_walk(op_a, base);
    step_cycle();
    qnt_en_i = 1'b0;
  end
  report_test("quantize");
endtask

task automatic backpressure_test();
  word_t op_a;
  int    cycles;
  op_a = $random(seed) % 160;
  fetched.delete();
  step_cycle();
  qnt_en_i   = 1'b1;
  qnt_op_a_i = op_a;
  qnt_op_b_i = 32'h40;
  wb_ready_i = 1'b0;
  cycles     = 0;
  // Run until the last threshold comes back
  do begin
    @(negedge clk);
    cycles++;
    compare_value("ex_ready_o", ex_ready_o, 1'b0);
  end while (!(fetched.size() == `QNT_LEVELS && data_rvalid_ex_i)
             && cycles < WORST_QNT_CYCLES);
  require_true(cycles < WORST_QNT_CYCLES, "walk under back-pressure did not finish");
  @(negedge clk);
  repeat (6) begin
    @(negedge clk);
    compare_value("ex_ready_o", ex_ready_o, 1'b0);
    compare_value("ex_valid_o", ex_valid_o, 1'b0);
    check_walk(op_a, 32'h40);  // Result held while WB stalls
  end
  step_cycle();
  wb_ready_i = 1'b1;
  @(negedge clk);
  compare_value("ex_ready_o", ex_ready_o, 1'b1);
  compare_value("ex_valid_o", ex_valid_o, 1'b1);
  check_walk(op_a, 32'h40);
  step_cycle();
  qnt_en_i = 1'b0;
  report_test("backpressure");
endtask

task automatic lsu_port_test();
  step_cycle();
  lsu_en_i        = 1'b1;
  regfile_we_i    = 1'b1;
  regfile_waddr_i = 6'h15;
  lsu_rdata_i     = 32'hCAFE_0123;
  @(negedge clk);
  compare_value("ex_valid_o", ex_valid_o, 1'b1);
  step_cycle();
  lsu_en_i        = 1'b0;
  regfile_we_i    = 1'b0;
  regfile_waddr_i = 6'h00;
  @(negedge clk);
  compare_value("regfile_we_wb_o", regfile_we_wb_o, 1'b1);
  compare_value("regfile_waddr_wb_o", regfile_waddr_wb_o, 6'h15);
  compare_value("regfile_wdata_wb_o", regfile_wdata_wb_o, 32'hCAFE_0123);
  step_cycle();
  @(negedge clk);
  compare_value("regfile_we_wb_o", regfile_we_wb_o, 1'b0);  // Bubble cleared it
  // Faulting load
  step_cycle();
  lsu_en_i        = 1'b1;
  regfile_we_i    = 1'b1;
  lsu_err_i       = 1'b1;
  regfile_waddr_i = 6'h2A;
  step_cycle();
  lsu_en_i     = 1'b0;
  regfile_we_i = 1'b0;
  lsu_err_i    = 1'b0;
  @(negedge clk);
  compare_value("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
  compare_value("regfile_waddr_wb_o", regfile_waddr_wb_o, 6'h15);
  report_test("lsu_port");
endtask

// ==== tests/ex_stage_tb.sv ====
// Testbench of the execute stage with a threshold memory model and a watchdog
// Compile with files.f and simulate ex_stage_tb as the top module
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_stage_tb import ex_pkg::*; ();

  localparam int CLK_PERIOD       = 40;
  localparam int NUM_TESTS        = 6;
  localparam int W                = `EX_WORD_W;
  localparam int MEM_WORDS        = 64;
  localparam int WORST_QNT_CYCLES = `QNT_LEVELS * 8 + 2;  // Up to 3 + 3 wait cycles per level

  logic      clk;
  logic      rst_n;
  logic      alu_en_i;
  alu_op_e   alu_operator_i;
  word_t     alu_operand_a_i;
  word_t     alu_operand_b_i;
  word_t     alu_operand_c_i;
  logic      mult_en_i;
  mult_op_e  mult_operator_i;
  word_t     mult_operand_a_i;
  word_t     mult_operand_b_i;
  word_t     mult_operand_c_i;
  logic      qnt_en_i;
  word_t     qnt_op_a_i;
  word_t     qnt_op_b_i;
  logic      qnt_thresh_req_o;
  word_t     qnt_thresh_addr_o;
  logic      data_gnt_mem_i;
  logic      data_rvalid_ex_i;
  logic      lsu_en_i;
  word_t     lsu_rdata_i;
  logic      lsu_ready_ex_i;
  logic      lsu_err_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      branch_in_ex_i;
  word_t     jump_target_o;
  logic      branch_decision_o;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic      regfile_alu_we_fw_o;
  reg_addr_t regfile_alu_waddr_fw_o;
  word_t     regfile_alu_wdata_fw_o;
  logic      regfile_we_wb_o;
  reg_addr_t regfile_waddr_wb_o;
  word_t     regfile_wdata_wb_o;
  logic      ex_ready_o;
  logic      ex_valid_o;
  logic      wb_ready_i;

  integer seed = 53;
  int     test_errs = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     total_errs = 0;

  word_t  thresh_mem [MEM_WORDS];
  word_t  fetched [$];  // Granted threshold addresses, oldest first

  always #(CLK_PERIOD / 2) clk = ~clk;

  ex_stage u_ex_stage (.*);

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic step_cycle();
    @(posedge clk);
    #2;  // Drive point after the edge
  endtask

  task automatic set_idle_inputs();
    alu_en_i            = 1'b0;
    alu_operator_i      = ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_en_i           = 1'b0;
    mult_operator_i     = MUL_MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_operand_c_i    = '0;
    qnt_en_i            = 1'b0;
    qnt_op_a_i          = '0;
    qnt_op_b_i          = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  task automatic return_to_idle();
    step_cycle();
    set_idle_inputs();
  endtask

  task automatic compare_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic require_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Check failed: %s", what);
      test_errs++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("%-14s PASS", name);
    end else begin
      $display("%-14s FAIL with %0d errors", name, test_errs);
      tests_failed++;
      total_errs += test_errs;
    end
    test_errs = 0;
  endtask

  function automatic word_t thresh_at(input word_t addr);
    return thresh_mem[addr[7:2]];
  endfunction

  `include "ex_stage_tests.svh"

  //////////////////////////////////////////////////////////////////////
  // Threshold memory behind the req/gnt/rvalid strobes
  //////////////////////////////////////////////////////////////////////

  initial begin : mem_model
    int    gnt_wait;
    int    rv_wait;
    word_t addr;
    data_gnt_mem_i   = 1'b0;
    data_rvalid_ex_i = 1'b0;
    forever begin
      step_cycle();
      data_gnt_mem_i   = 1'b0;
      data_rvalid_ex_i = 1'b0;
      if (rst_n && qnt_thresh_req_o) begin
        gnt_wait = {$random(seed)} % 4;
        rv_wait  = {$random(seed)} % 4;
        repeat (gnt_wait) step_cycle();
        data_gnt_mem_i = 1'b1;
        addr           = qnt_thresh_addr_o;  // Held steady until this grant
        fetched.push_back(addr);
        step_cycle();
        data_gnt_mem_i = 1'b0;
        repeat (rv_wait) step_cycle();
        data_rvalid_ex_i = 1'b1;
        lsu_rdata_i      = thresh_at(addr);
      end
    end
  end

  initial begin : watchdog
    #(NUM_TESTS * WORST_QNT_CYCLES * 4 * CLK_PERIOD);
    $display("Watchdog expired before the test sequence completed");
    $display("tests failed");
    $finish;
  end

  initial begin : test_sequence
    int i;
    for (i = 0; i < MEM_WORDS; i++) begin
      thresh_mem[i] = $random(seed) % 128;  // Signed, within +-127
    end
    clk   = 1'b0;
    rst_n = 1'b0;
    set_idle_inputs();
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    alu_test();
    return_to_idle();
    branch_test();
    return_to_idle();
    mult_test();
    return_to_idle();
    quantize_test();
    return_to_idle();
    backpressure_test();
    return_to_idle();
    lsu_port_test();

    $display("Summary: %0d tests run, %0d with errors, %0d failed checks",
             tests_run, tests_failed, total_errs);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
